//--- Makefile
TOP := axis_input_pipe_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): src.f $(shell cat src.f)
	verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
	  --top-module $(TOP) -f src.f

test: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Simulation failed" sim.log; then \
	  echo "test: FAILED"; exit 1; \
	elif ! grep -q "Simulation passed" sim.log; then \
	  echo "test: no result found in sim.log"; exit 1; \
	else \
	  echo "test: PASSED"; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- axis_input_join.sv
`timescale 1ns/1ps
`default_nettype none

module axis_input_join (
  input  wire logic                                     aclk,
  input  wire logic                                     reset,

  axis_words_if.sink                                    win,
  axis_words_if.sink                                    wrow,

  output logic                                          m_tvalid,
  input  wire logic                                     m_tready,
  output cnn_pkg::word_t [cnn_pkg::UNITS-1:0]           m_pixels_tdata,
  output cnn_pkg::word_t [cnn_pkg::W_ROW_WORDS-1:0]     m_weights_tdata,
  output cnn_pkg::kernel_row_t                          m_kernel_row,
  output logic                                          m_tlast,
  output logic                                          sync_error
);
  import cnn_pkg::*;

  logic out_free;
  logic take;

  // Output register is empty or drains this cycle.
  assign out_free = !m_tvalid || m_tready;
  assign take     = win.valid && wrow.valid && out_free;

  // Each side is taken only together with the other.
  assign win.ready  = wrow.valid && out_free;
  assign wrow.ready = win.valid && out_free;

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (reset) begin
      m_tvalid <= 1'b0;
    end else if (take) begin
      m_tvalid <= 1'b1;
    end else if (m_tready) begin
      m_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      m_pixels_tdata  <= win.data;
      m_weights_tdata <= wrow.data;
      m_kernel_row    <= win.row;
      m_tlast         <= win.last;
    end
  end

  //////////////////////////////////////////////////
  // End marker check
  //////////////////////////////////////////////////

  // Sticky until reset.
  always_ff @(posedge aclk) begin
    if (reset) begin
      sync_error <= 1'b0;
    end else if (take && (win.last != wrow.last)) begin
      sync_error <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- axis_input_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module axis_input_pipe (
  input  wire logic                                     aclk,
  input  wire logic                                     reset,

  input  wire logic                                     s_pixels_tvalid,
  output logic                                          s_pixels_tready,
  input  wire cnn_pkg::word_t [cnn_pkg::UNITS_EDGES-1:0] s_pixels_tdata,
  input  wire logic                                     s_pixels_tlast,

  input  wire logic                                     s_weights_tvalid,
  output logic                                          s_weights_tready,
  input  wire cnn_pkg::word_t [cnn_pkg::W_IN_WORDS-1:0]  s_weights_tdata,
  input  wire logic                                     s_weights_tlast,

  output logic                                          m_tvalid,
  input  wire logic                                     m_tready,
  output cnn_pkg::word_t [cnn_pkg::UNITS-1:0]           m_pixels_tdata,
  output cnn_pkg::word_t [cnn_pkg::W_ROW_WORDS-1:0]     m_weights_tdata,
  output cnn_pkg::kernel_row_t                          m_kernel_row,
  output logic                                          m_tlast,
  output logic                                          sync_error
);
  import cnn_pkg::*;

  axis_words_if #(.WORDS(UNITS))       pix_win_if ();
  axis_words_if #(.WORDS(W_ROW_WORDS)) w_row_if ();

  //////////////////////////////////////////////////
  // Pixel and weight paths
  //////////////////////////////////////////////////

  pixel_row_shifter i_pixel_row_shifter (
    .aclk            (aclk),
    .reset           (reset),
    .s_pixels_tvalid (s_pixels_tvalid),
    .s_pixels_tready (s_pixels_tready),
    .s_pixels_tdata  (s_pixels_tdata),
    .s_pixels_tlast  (s_pixels_tlast),
    .win             (pix_win_if.source)
  );

  weight_row_packer i_weight_row_packer (
    .aclk             (aclk),
    .reset            (reset),
    .s_weights_tvalid (s_weights_tvalid),
    .s_weights_tready (s_weights_tready),
    .s_weights_tdata  (s_weights_tdata),
    .s_weights_tlast  (s_weights_tlast),
    .wrow             (w_row_if.source)
  );

  //////////////////////////////////////////////////
  // Join into MAC beats
  //////////////////////////////////////////////////

  axis_input_join i_axis_input_join (
    .aclk            (aclk),
    .reset           (reset),
    .win             (pix_win_if.sink),
    .wrow            (w_row_if.sink),
    .m_tvalid        (m_tvalid),
    .m_tready        (m_tready),
    .m_pixels_tdata  (m_pixels_tdata),
    .m_weights_tdata (m_weights_tdata),
    .m_kernel_row    (m_kernel_row),
    .m_tlast         (m_tlast),
    .sync_error      (sync_error)
  );

endmodule

`default_nettype wire

//--- axis_input_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axis_input_pipe_tb;
  import cnn_pkg::*;

  logic                           aclk;
  logic                           reset;
  logic                           s_pixels_tvalid;
  logic                           s_pixels_tready;
  word_t [UNITS_EDGES-1:0]        s_pixels_tdata;
  logic                           s_pixels_tlast;
  logic                           s_weights_tvalid;
  logic                           s_weights_tready;
  word_t [W_IN_WORDS-1:0]         s_weights_tdata;
  logic                           s_weights_tlast;
  logic                           m_tvalid;
  logic                           m_tready;
  word_t [UNITS-1:0]              m_pixels_tdata;
  word_t [W_ROW_WORDS-1:0]        m_weights_tdata;
  kernel_row_t                    m_kernel_row;
  logic                           m_tlast;
  logic                           sync_error;

  // Input beats still to send.
  logic [UNITS_EDGES*WORD_WIDTH-1:0] pix_in[$];
  bit                                pix_last_in[$];
  logic [W_IN_WORDS*WORD_WIDTH-1:0]  w_in[$];
  bit                                w_last_in[$];

  // Expected output beats, oldest first.
  logic [UNITS*WORD_WIDTH-1:0]       exp_pix[$];
  logic [W_ROW_WORDS*WORD_WIDTH-1:0] exp_w[$];
  kernel_row_t                       exp_row[$];
  bit                                exp_last[$];
  bit                                exp_err[$];  // Pair with unequal end markers.

  bit                                err_seen;
  bit                                expect_err;
  bit                                was_stalled;
  logic [UNITS*WORD_WIDTH-1:0]       held_pix;
  logic [W_ROW_WORDS*WORD_WIDTH-1:0] held_w;
  kernel_row_t                       held_row;
  logic                              held_last;

  axis_input_pipe i_dut (
    .aclk             (aclk),
    .reset            (reset),
    .s_pixels_tvalid  (s_pixels_tvalid),
    .s_pixels_tready  (s_pixels_tready),
    .s_pixels_tdata   (s_pixels_tdata),
    .s_pixels_tlast   (s_pixels_tlast),
    .s_weights_tvalid (s_weights_tvalid),
    .s_weights_tready (s_weights_tready),
    .s_weights_tdata  (s_weights_tdata),
    .s_weights_tlast  (s_weights_tlast),
    .m_tvalid         (m_tvalid),
    .m_tready         (m_tready),
    .m_pixels_tdata   (m_pixels_tdata),
    .m_weights_tdata  (m_weights_tdata),
    .m_kernel_row     (m_kernel_row),
    .m_tlast          (m_tlast),
    .sync_error       (sync_error)
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  // Output side accepts roughly one cycle in three.
  initial begin
    m_tready = 1'b0;
    forever begin
      @(posedge aclk);
      #1;
      m_tready = ($urandom % 3) == 0;
    end
  end

  task automatic value_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
    $display("FAIL at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic abort_run(string reason);
    $display("ERROR at %0t: %s", $time, reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////
  // Stimulus and reference model
  //////////////////////////////////////////////////

  task automatic build_image(int cols, bit early_end);
    logic [UNITS_EDGES*WORD_WIDTH-1:0]  col;
    logic [W_ROW_WORDS*WORD_WIDTH-1:0]  wrow;
    int                                 last_row_idx;
    int                                 row_idx;
    bit                                 col_last;
    bit                                 row_last;
    last_row_idx = early_end ? KERNEL_H * cols - 2 : KERNEL_H * cols - 1;
    for (int c = 0; c < cols; c++) begin
      col      = $urandom();
      col_last = (c == cols - 1);
      pix_in.push_back(col);
      pix_last_in.push_back(col_last);
      for (int r = 0; r < KERNEL_H; r++) begin
        row_idx     = KERNEL_H * c + r;
        row_last    = (row_idx == last_row_idx);
        wrow[31:0]  = $urandom();
        wrow[47:32] = 16'($urandom());
        // Beat k fills row words 2k and 2k+1.
        for (int b = 0; b < W_BEATS_PER_ROW; b++) begin
          w_in.push_back(wrow[b*W_IN_WORDS*WORD_WIDTH +: W_IN_WORDS*WORD_WIDTH]);
          w_last_in.push_back(row_last && (b == W_BEATS_PER_ROW - 1));
        end
        exp_pix.push_back(col[r*WORD_WIDTH +: UNITS*WORD_WIDTH]);
        exp_w.push_back(wrow);
        exp_row.push_back(kernel_row_t'(r));
        exp_last.push_back(col_last && (r == KERNEL_H - 1));
        exp_err.push_back((col_last && (r == KERNEL_H - 1)) != row_last);
      end
    end
  endtask

  task automatic drive_pixels();
    int waited;
    while (pix_in.size() != 0) begin
      @(posedge aclk);
      #1;
      s_pixels_tdata  = pix_in[0];
      s_pixels_tlast  = pix_last_in[0];
      s_pixels_tvalid = ($urandom % 4) != 0;
      if (s_pixels_tvalid) begin
        waited = 0;
        @(negedge aclk);
        while (!s_pixels_tready) begin
          waited++;
          if (waited > 500) abort_run("pixel input stayed not ready");
          @(negedge aclk);
        end
        void'(pix_in.pop_front());      // Transfers at the coming edge.
        void'(pix_last_in.pop_front());
      end
    end
    @(posedge aclk);
    #1;
    s_pixels_tvalid = 1'b0;
  endtask

  task automatic drive_weights();
    int waited;
    while (w_in.size() != 0) begin
      @(posedge aclk);
      #1;
      s_weights_tdata  = w_in[0];
      s_weights_tlast  = w_last_in[0];
      s_weights_tvalid = ($urandom % 4) != 0;
      if (s_weights_tvalid) begin
        waited = 0;
        @(negedge aclk);
        while (!s_weights_tready) begin
          waited++;
          if (waited > 500) abort_run("weight input stayed not ready");
          @(negedge aclk);
        end
        void'(w_in.pop_front());
        void'(w_last_in.pop_front());
      end
    end
    @(posedge aclk);
    #1;
    s_weights_tvalid = 1'b0;
  endtask

  task automatic apply_reset();
    reset            = 1'b1;
    s_pixels_tvalid  = 1'b0;
    s_weights_tvalid = 1'b0;
    repeat (2) @(posedge aclk);
    #1;
    reset = 1'b0;
  endtask

  task automatic check_idle();
    @(negedge aclk);
    assert (m_tvalid == 1'b0) else value_mismatch("m_tvalid", 0, 64'(m_tvalid));
    assert (sync_error == 1'b0) else value_mismatch("sync_error", 0, 64'(sync_error));
    assert (s_pixels_tready) else value_mismatch("s_pixels_tready", 1, 64'(s_pixels_tready));
    assert (s_weights_tready) else value_mismatch("s_weights_tready", 1, 64'(s_weights_tready));
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_pix.size() != 0) begin
      waited++;
      if (waited > 3000) abort_run("expected outputs did not arrive in time");
      @(negedge aclk);
    end
    @(posedge aclk);
    #1;
  endtask

  //////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////

  always @(negedge aclk) begin
    if (reset) begin
      err_seen    = 1'b0;
      was_stalled = 1'b0;
    end else begin
      if (was_stalled) begin                 // Output must hold while stalled.
        assert (m_tvalid) else value_mismatch("m_tvalid", 1, 64'(m_tvalid));
        assert (m_pixels_tdata == held_pix)
          else value_mismatch("m_pixels_tdata", 64'(held_pix), 64'(m_pixels_tdata));
        assert (m_weights_tdata == held_w)
          else value_mismatch("m_weights_tdata", 64'(held_w), 64'(m_weights_tdata));
        assert (m_kernel_row == held_row)
          else value_mismatch("m_kernel_row", 64'(held_row), 64'(m_kernel_row));
        assert (m_tlast == held_last)
          else value_mismatch("m_tlast", 64'(held_last), 64'(m_tlast));
      end
      if (m_tvalid) begin
        assert (exp_pix.size() != 0) else abort_run("output beat arrived with none expected");
        assert (m_pixels_tdata == exp_pix[0])
          else value_mismatch("m_pixels_tdata", 64'(exp_pix[0]), 64'(m_pixels_tdata));
        assert (m_weights_tdata == exp_w[0])
          else value_mismatch("m_weights_tdata", 64'(exp_w[0]), 64'(m_weights_tdata));
        assert (m_kernel_row == exp_row[0])
          else value_mismatch("m_kernel_row", 64'(exp_row[0]), 64'(m_kernel_row));
        assert (m_tlast == exp_last[0])
          else value_mismatch("m_tlast", 64'(exp_last[0]), 64'(m_tlast));
      end
      // The pair in the output register has already been compared.
      expect_err = err_seen;
      if (m_tvalid && exp_err[0]) expect_err = 1'b1;
      assert (sync_error == expect_err)
        else value_mismatch("sync_error", 64'(expect_err), 64'(sync_error));
      if (m_tvalid && m_tready) begin
        if (exp_err[0]) err_seen = 1'b1;
        void'(exp_pix.pop_front());
        void'(exp_w.pop_front());
        void'(exp_row.pop_front());
        void'(exp_last.pop_front());
        void'(exp_err.pop_front());
        was_stalled = 1'b0;
      end else if (m_tvalid) begin
        was_stalled = 1'b1;
        held_pix    = m_pixels_tdata;
        held_w      = m_weights_tdata;
        held_row    = m_kernel_row;
        held_last   = m_tlast;
      end else begin
        was_stalled = 1'b0;
      end
    end
  end

  initial begin
    void'($urandom(32'h8698));
    reset            = 1'b1;
    s_pixels_tvalid  = 1'b0;
    s_pixels_tdata   = '0;
    s_pixels_tlast   = 1'b0;
    s_weights_tvalid = 1'b0;
    s_weights_tdata  = '0;
    s_weights_tlast  = 1'b0;
    apply_reset();
    check_idle();

    // Images with matching end markers.
    for (int i = 0; i < 5; i++) begin
      build_image(1 + int'($urandom % 4), 1'b0);
    end
    fork
      drive_pixels();
      drive_weights();
    join
    wait_drained();
    @(negedge aclk);
    assert (sync_error == 1'b0) else value_mismatch("sync_error", 0, 64'(sync_error));

    // Weights of the final image end one row early.
    build_image(3, 1'b1);
    fork
      drive_pixels();
      drive_weights();
    join
    wait_drained();
    for (int i = 0; i < 8; i++) begin
      @(negedge aclk);
      assert (sync_error) else value_mismatch("sync_error", 1, 64'(sync_error));
    end

    @(posedge aclk);
    #1;
    apply_reset();
    check_idle();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- axis_words_if.sv
`timescale 1ns/1ps
`default_nettype none

// Stream of WORDS words with valid/ready/last handshake.
interface axis_words_if #(
  parameter int WORDS = 1
);
  import cnn_pkg::*;

  logic                   valid;
  logic                   ready;
  logic                   last;
  word_t [WORDS-1:0]      data;
  kernel_row_t            row;    // Kernel row of a pixel window.

  modport source (
    output valid,
    output last,
    output data,
    output row,
    input  ready
  );

  modport sink (
    input  valid,
    input  last,
    input  data,
    input  row,
    output ready
  );

endinterface

`default_nettype wire

//--- cnn_pkg.sv
`default_nettype none

package cnn_pkg;

  //////////////////////////////////////////////////
  // Array sizes
  //////////////////////////////////////////////////

  localparam int WORD_WIDTH = 8;       // Bits per pixel or weight word.
  localparam int UNITS      = 2;       // Output rows computed side by side.
  localparam int KERNEL_H   = 3;
  localparam int KERNEL_W   = 3;
  localparam int CORES      = 2;       // Output channels computed side by side.

  // A pixel beat carries the unit rows plus the halo above and below.
  localparam int UNITS_EDGES = UNITS + KERNEL_H - 1;

  //////////////////////////////////////////////////
  // Weight stream
  //////////////////////////////////////////////////

  localparam int W_IN_WORDS      = 2;                         // Words per input beat.
  localparam int W_ROW_WORDS     = CORES * KERNEL_W;          // One kernel row per core.
  localparam int W_BEATS_PER_ROW = W_ROW_WORDS / W_IN_WORDS;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // One pixel or one weight.
  typedef logic [WORD_WIDTH-1:0] word_t;

  // Kernel row index, 0 to KERNEL_H-1.
  typedef logic [1:0] kernel_row_t;

  // Position of a narrow weight beat inside its kernel row.
  typedef logic [$clog2(W_BEATS_PER_ROW)-1:0] w_beat_t;

endpackage

`default_nettype wire

//--- pixel_row_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_row_shifter (
  input  wire logic                                     aclk,
  input  wire logic                                     reset,

  input  wire logic                                     s_pixels_tvalid,
  output logic                                          s_pixels_tready,
  input  wire cnn_pkg::word_t [cnn_pkg::UNITS_EDGES-1:0] s_pixels_tdata,
  input  wire logic                                     s_pixels_tlast,

  axis_words_if.source                                  win
);
  import cnn_pkg::*;

  word_t [UNITS_EDGES-1:0] col_q;
  logic                    last_q;
  logic                    full_q;
  kernel_row_t             row_q;

  logic                    s_take;
  logic                    win_take;
  logic                    last_row;

  assign last_row = (row_q == kernel_row_t'(KERNEL_H - 1));
  assign win_take = win.valid && win.ready;

  // A new column can enter as the final window of the old one leaves.
  assign s_pixels_tready = !full_q || (win_take && last_row);
  assign s_take          = s_pixels_tvalid && s_pixels_tready;

  //////////////////////////////////////////////////
  // Column register and row counter
  //////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (reset) begin
      full_q <= 1'b0;
      row_q  <= '0;
    end else if (s_take) begin
      full_q <= 1'b1;
      row_q  <= '0;
    end else if (win_take) begin
      if (last_row) begin
        full_q <= 1'b0;
        row_q  <= '0;
      end else begin
        row_q <= row_q + kernel_row_t'(1);
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (s_take) begin
      col_q  <= s_pixels_tdata;
      last_q <= s_pixels_tlast;
    end
  end

  //////////////////////////////////////////////////
  // Window output
  //////////////////////////////////////////////////

  // Kernel row r sees column words r .. r+UNITS-1.
  always_comb begin
    for (int i = 0; i < UNITS; i++) begin
      win.data[i] = col_q[int'(row_q) + i];
    end
  end

  assign win.valid = full_q;
  assign win.row   = row_q;
  assign win.last  = last_q && last_row;    // Only the final window of the image.

endmodule

`default_nettype wire

//--- src.f
cnn_pkg.sv
axis_words_if.sv
pixel_row_shifter.sv
weight_row_packer.sv
axis_input_join.sv
axis_input_pipe.sv
axis_input_pipe_tb.sv

//--- weight_row_packer.sv
`timescale 1ns/1ps
`default_nettype none

module weight_row_packer (
  input  wire logic                                    aclk,
  input  wire logic                                    reset,

  input  wire logic                                    s_weights_tvalid,
  output logic                                         s_weights_tready,
  input  wire cnn_pkg::word_t [cnn_pkg::W_IN_WORDS-1:0] s_weights_tdata,
  input  wire logic                                    s_weights_tlast,

  axis_words_if.source                                 wrow
);
  import cnn_pkg::*;

  // Row layout: word j is core j/KERNEL_W, kernel column j%KERNEL_W.
  word_t [W_ROW_WORDS-1:0] row_q;
  logic                    last_q;
  logic                    full_q;
  w_beat_t                 beat_q;

  logic                    s_take;
  logic                    wrow_take;
  logic                    final_beat;

  assign wrow_take  = wrow.valid && wrow.ready;
  assign final_beat = (beat_q == w_beat_t'(W_BEATS_PER_ROW - 1));

  assign s_weights_tready = !full_q || wrow_take;
  assign s_take           = s_weights_tvalid && s_weights_tready;

  //////////////////////////////////////////////////
  // Beat counter
  //////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (reset) begin
      full_q <= 1'b0;
      beat_q <= '0;
    end else begin
      if (wrow_take) begin
        full_q <= 1'b0;
      end
      if (s_take) begin
        if (final_beat) begin
          full_q <= 1'b1;                   // Row complete, hold until taken.
          beat_q <= '0;
        end else begin
          beat_q <= beat_q + w_beat_t'(1);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Row assembly
  //////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (s_take) begin
      for (int i = 0; i < W_IN_WORDS; i++) begin
        row_q[W_IN_WORDS * int'(beat_q) + i] <= s_weights_tdata[i];
      end
      if (final_beat) begin
        last_q <= s_weights_tlast;
      end
    end
  end

  assign wrow.valid = full_q;
  assign wrow.data  = row_q;
  assign wrow.last  = last_q;
  assign wrow.row   = '0;                   // Unused on the weight path.

endmodule

`default_nettype wire
